// File: common/mem_pkg.sv
package mem_pkg;

    // data side operation, loads first then stores
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd3,
        LHU = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } mem_op_e;

    // instruction fetch, word aligned only
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } ireq_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } iresp_t;

    // store data sits in the low bits of wdata
    typedef struct packed {
        logic        valid;
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dreq_t;

    // rdata already extended to 32 bits
    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } dresp_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [3:0]  sel;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_resp_t;

    // timer words: mtime lo/hi at +0/+4, mtimecmp lo/hi at +8/+12
    localparam logic [31:0] TIMER_BASE = 32'hF000_0000;

endpackage

// File: mem_map/word_ram.sv
`timescale 1ns/10ps

module word_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                         clkConstrained,
    input  logic                         en,
    input  logic                         we,
    input  logic [$clog2(RAM_WORDS)-1:0] word_addr,
    input  logic [3:0]                   sel,
    input  logic [31:0]                  wdata,
    output logic [31:0]                  rdata
);

    logic [31:0] mem [RAM_WORDS];

    // byte lane writes, read returns the old word on a write
    always_ff @(posedge clkConstrained) begin
        if (en) begin
            if (we) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel[b]) begin
                        mem[word_addr][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end
            rdata <= mem[word_addr];
        end
    end

endmodule

// File: mem_map/machine_timer.sv
`timescale 1ns/10ps

module machine_timer #(
    parameter int FMAX_MHZ = 27
) (
    input  logic        clkConstrained,
    input  logic        arst_n,
    input  logic        wr,
    input  logic [1:0]  reg_index,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        timer_irq
);

    localparam int PW = $clog2(FMAX_MHZ + 1);

    logic [PW-1:0] prescale;
    logic [63:0]   mtime;
    logic [63:0]   mtimecmp;

    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            prescale  <= '0;
            mtime     <= 64'h0;
            mtimecmp  <= '1;
            timer_irq <= 1'b0;
        end else begin
            // one mtime tick per microsecond
            if (prescale == PW'(FMAX_MHZ - 1)) begin
                prescale <= '0;
                mtime    <= mtime + 64'd1;
            end else begin
                prescale <= prescale + 1'b1;
            end
            // mtime itself is read only
            if (wr) begin
                case (reg_index)
                    2'd2:    mtimecmp[31:0]  <= wdata;
                    2'd3:    mtimecmp[63:32] <= wdata;
                    default: mtimecmp        <= mtimecmp;
                endcase
            end
            timer_irq <= (mtime >= mtimecmp);
        end
    end

    always_ff @(posedge clkConstrained) begin
        case (reg_index)
            2'd0:    rdata <= mtime[31:0];
            2'd1:    rdata <= mtime[63:32];
            2'd2:    rdata <= mtimecmp[31:0];
            default: rdata <= mtimecmp[63:32];
        endcase
    end

endmodule

// File: mem_map/mem_map_ctrl.sv
`timescale 1ns/10ps

module mem_map_ctrl #(
    parameter int FMAX_MHZ  = 27,
    parameter int RAM_WORDS = 1024
) (
    input  logic              clkConstrained,
    input  logic              arst_n,
    input  mem_pkg::wb_req_t  wb_in,
    output mem_pkg::wb_resp_t wb_out,
    output logic              timer_irq
);

    localparam int          AW        = $clog2(RAM_WORDS);
    localparam logic [31:0] RAM_BYTES = 32'(RAM_WORDS * 4);

    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_RAM,
        TGT_TIMER
    } target_e;

    target_e     target;
    target_e     target_q;
    logic        access;
    logic        ack_q;
    logic [31:0] ram_rdata;
    logic [31:0] timer_rdata;

    // first cycle of a strobe, the ack cycle itself is excluded
    assign access = wb_in.cyc && wb_in.stb && !ack_q;

    always_comb begin
        if (wb_in.adr < RAM_BYTES) begin
            target = TGT_RAM;
        end else if (wb_in.adr[31:4] == mem_pkg::TIMER_BASE[31:4]) begin
            target = TGT_TIMER;
        end else begin
            target = TGT_NONE;
        end
    end

    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            ack_q    <= 1'b0;
            target_q <= TGT_NONE;
        end else begin
            ack_q <= access;
            if (access) begin
                target_q <= target;
            end
        end
    end

    word_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) u_ram (
        .clkConstrained(clkConstrained),
        .en            (access && target == TGT_RAM),
        .we            (wb_in.we),
        .word_addr     (wb_in.adr[AW+1:2]),
        .sel           (wb_in.sel),
        .wdata         (wb_in.dat),
        .rdata         (ram_rdata)
    );

    machine_timer #(
        .FMAX_MHZ(FMAX_MHZ)
    ) u_timer (
        .clkConstrained(clkConstrained),
        .arst_n        (arst_n),
        .wr            (access && target == TGT_TIMER && wb_in.we),
        .reg_index     (wb_in.adr[3:2]),
        .wdata         (wb_in.dat),
        .rdata         (timer_rdata),
        .timer_irq     (timer_irq)
    );

    // unmapped space reads as zero
    assign wb_out.ack = ack_q;
    assign wb_out.dat = (target_q == TGT_RAM)   ? ram_rdata   :
                        (target_q == TGT_TIMER) ? timer_rdata : 32'h0;

endmodule

// File: verilog/data_access_splitter.sv
`timescale 1ns/10ps

module data_access_splitter (
    input  logic            clkConstrained,
    input  logic            arst_n,
    input  mem_pkg::dreq_t  dreq,
    output mem_pkg::dresp_t dresp,
    output mem_pkg::dreq_t  word_req,
    output logic [3:0]      word_sel,
    input  mem_pkg::dresp_t word_resp
);

    typedef enum logic [1:0] {
        IDLE,
        FIRST,
        SECOND,
        DONE
    } split_state_e;

    split_state_e state;

    logic [1:0]  offset;
    logic [29:0] word_index;
    logic [3:0]  size_mask;
    logic [7:0]  lane_mask;
    logic [63:0] wdata_wide;
    logic        is_store;
    logic        crosses;
    logic [31:0] lo_word;
    logic [31:0] hi_word;
    logic [63:0] load_window;
    logic [31:0] load_bytes;

    assign offset     = dreq.addr[1:0];
    assign word_index = dreq.addr[31:2];

    always_comb begin
        case (dreq.op)
            mem_pkg::LB, mem_pkg::LBU, mem_pkg::SB: size_mask = 4'b0001;
            mem_pkg::LH, mem_pkg::LHU, mem_pkg::SH: size_mask = 4'b0011;
            default:                                size_mask = 4'b1111;
        endcase
    end

    // byte lanes over two adjacent words, upper half is the next word
    assign is_store   = dreq.op inside {mem_pkg::SB, mem_pkg::SH, mem_pkg::SW};
    assign lane_mask  = {4'b0000, size_mask} << offset;
    assign wdata_wide = {32'h0, dreq.wdata} << {offset, 3'b000};
    assign crosses    = |lane_mask[7:4];

    // first word goes out in the same cycle as dreq to keep aligned latency
    always_comb begin
        word_req.valid = 1'b0;
        word_req.op    = is_store ? mem_pkg::SW : mem_pkg::LW;
        word_req.addr  = {word_index, 2'b00};
        word_req.wdata = wdata_wide[31:0];
        word_sel       = lane_mask[3:0];
        case (state)
            IDLE, FIRST: begin
                word_req.valid = dreq.valid;
            end
            SECOND: begin
                word_req.valid = dreq.valid;
                word_req.addr  = {word_index + 30'd1, 2'b00};
                word_req.wdata = wdata_wide[63:32];
                word_sel       = lane_mask[7:4];
            end
            default: word_req.valid = 1'b0;
        endcase
    end

    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (dreq.valid) begin
                        state <= FIRST;
                    end
                end
                FIRST: begin
                    if (word_resp.valid) begin
                        state <= crosses ? SECOND : IDLE;
                    end
                end
                SECOND: begin
                    if (word_resp.valid) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // both halves of a split load
    always_ff @(posedge clkConstrained) begin
        if (word_resp.valid && state == FIRST) begin
            lo_word <= word_resp.rdata;
        end
        if (word_resp.valid && state == SECOND) begin
            hi_word <= word_resp.rdata;
        end
    end

    assign load_window = (state == DONE) ? {hi_word, lo_word} : {32'h0, word_resp.rdata};
    assign load_bytes  = 32'(load_window >> {offset, 3'b000});

    // single word answers straight from the bus response
    always_comb begin
        dresp.valid = (state == DONE) || (state == FIRST && word_resp.valid && !crosses);
        case (dreq.op)
            mem_pkg::LB:  dresp.rdata = {{24{load_bytes[7]}}, load_bytes[7:0]};
            mem_pkg::LH:  dresp.rdata = {{16{load_bytes[15]}}, load_bytes[15:0]};
            mem_pkg::LW:  dresp.rdata = load_bytes;
            mem_pkg::LBU: dresp.rdata = {24'h0, load_bytes[7:0]};
            mem_pkg::LHU: dresp.rdata = {16'h0, load_bytes[15:0]};
            default:      dresp.rdata = 32'h0;
        endcase
    end

endmodule

// File: verilog/mem_cmd_arbiter.sv
`timescale 1ns/10ps

module mem_cmd_arbiter (
    input  logic              clkConstrained,
    input  logic              arst_n,
    input  mem_pkg::ireq_t    ireq,
    output mem_pkg::iresp_t   iresp,
    input  mem_pkg::dreq_t    word_req,
    input  logic [3:0]        word_sel,
    output mem_pkg::dresp_t   word_resp,
    output mem_pkg::wb_req_t  wb_out,
    input  mem_pkg::wb_resp_t wb_in
);

    typedef enum logic [1:0] {
        IDLE,
        BUS_DATA,
        BUS_FETCH,
        RESPOND
    } arb_state_e;

    arb_state_e  state;
    logic        owner_data;
    logic [31:0] rdata_q;

    // data side wins when both are waiting
    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            owner_data <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (word_req.valid) begin
                        state      <= BUS_DATA;
                        owner_data <= 1'b1;
                    end else if (ireq.valid) begin
                        state      <= BUS_FETCH;
                        owner_data <= 1'b0;
                    end
                end
                BUS_DATA, BUS_FETCH: begin
                    if (wb_in.ack) begin
                        state <= RESPOND;
                    end
                end
                // one cycle here lets the requester drop or change valid
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clkConstrained) begin
        if (wb_in.ack) begin
            rdata_q <= wb_in.dat;
        end
    end

    // requesters hold their request until the response, so a mux is enough
    always_comb begin
        wb_out.cyc = (state == BUS_DATA) || (state == BUS_FETCH);
        wb_out.stb = wb_out.cyc;
        wb_out.we  = 1'b0;
        wb_out.adr = 32'h0;
        wb_out.sel = 4'h0;
        wb_out.dat = 32'h0;
        if (state == BUS_DATA) begin
            wb_out.we  = (word_req.op == mem_pkg::SW);
            wb_out.adr = {word_req.addr[31:2], 2'b00};
            wb_out.sel = word_sel;
            wb_out.dat = word_req.wdata;
        end else if (state == BUS_FETCH) begin
            wb_out.adr = {ireq.addr[31:2], 2'b00};
            wb_out.sel = 4'hF;
        end
    end

    assign iresp.valid     = (state == RESPOND) && !owner_data;
    assign iresp.rdata     = rdata_q;
    assign word_resp.valid = (state == RESPOND) && owner_data;
    assign word_resp.rdata = rdata_q;

endmodule

// File: verilog/soc_mem_top.sv
`timescale 1ns/10ps

module soc_mem_top #(
    parameter int FMAX_MHZ  = 27,
    parameter int RAM_WORDS = 1024
) (
    input  logic            clkConstrained,
    input  logic            arst_n,
    input  mem_pkg::ireq_t  ireq,
    output mem_pkg::iresp_t iresp,
    input  mem_pkg::dreq_t  dreq,
    output mem_pkg::dresp_t dresp,
    output logic            timer_irq
);

    mem_pkg::dreq_t    word_req;
    logic [3:0]        word_sel;
    mem_pkg::dresp_t   word_resp;
    mem_pkg::wb_req_t  wb_req;
    mem_pkg::wb_resp_t wb_resp;

    data_access_splitter u_splitter (
        .clkConstrained(clkConstrained),
        .arst_n        (arst_n),
        .dreq          (dreq),
        .dresp         (dresp),
        .word_req      (word_req),
        .word_sel      (word_sel),
        .word_resp     (word_resp)
    );

    mem_cmd_arbiter u_arbiter (
        .clkConstrained(clkConstrained),
        .arst_n        (arst_n),
        .ireq          (ireq),
        .iresp         (iresp),
        .word_req      (word_req),
        .word_sel      (word_sel),
        .word_resp     (word_resp),
        .wb_out        (wb_req),
        .wb_in         (wb_resp)
    );

    mem_map_ctrl #(
        .FMAX_MHZ (FMAX_MHZ),
        .RAM_WORDS(RAM_WORDS)
    ) u_mem_map (
        .clkConstrained(clkConstrained),
        .arst_n        (arst_n),
        .wb_in         (wb_req),
        .wb_out        (wb_resp),
        .timer_irq     (timer_irq)
    );

endmodule

// File: sim/soc_mem_properties.sv
`timescale 1ns/10ps

module soc_mem_properties (
    input logic              clkConstrained,
    input logic              arst_n,
    input mem_pkg::wb_req_t  wb_in,
    input mem_pkg::wb_resp_t wb_out
);

    // no strobe outside a bus cycle
    assert property (@(posedge clkConstrained) disable iff (!arst_n)
        wb_in.stb |-> wb_in.cyc)
        else $error("wishbone stb without cyc");

    assert property (@(posedge clkConstrained) disable iff (!arst_n)
        wb_out.ack |-> (wb_in.cyc && wb_in.stb))
        else $error("wishbone ack outside an active strobe");

    // single beat cycles only
    assert property (@(posedge clkConstrained) disable iff (!arst_n)
        wb_out.ack |=> !wb_out.ack)
        else $error("wishbone ack high two cycles in a row");

    // request fields frozen until the slave answers
    assert property (@(posedge clkConstrained) disable iff (!arst_n)
        (wb_in.stb && !wb_out.ack) |=>
            $stable({wb_in.we, wb_in.adr, wb_in.sel, wb_in.dat}))
        else $error("wishbone request changed before ack");

endmodule

// File: sim/tb_soc_mem.sv
`timescale 1ns/10ps

module tb_soc_mem;

    localparam int RAM_WORDS = 256;
    localparam int RAM_BYTES = RAM_WORDS * 4;
    localparam int BW        = $clog2(RAM_BYTES);
    localparam int TIMEOUT   = 200;

    logic            clkConstrained = 1'b0;
    logic            arst_n;
    mem_pkg::ireq_t  ireq;
    mem_pkg::iresp_t iresp;
    mem_pkg::dreq_t  dreq;
    mem_pkg::dresp_t dresp;
    logic            timer_irq;

    // byte image of the RAM, expected responses as {check, value}
    logic [7:0]  shadow [RAM_BYTES];
    logic [32:0] exp_d [$];
    logic [32:0] exp_i [$];
    logic [31:0] lfsr;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    int          d_stamp;
    int          i_stamp;
    int          d_count = 0;
    int          i_count = 0;

    always #4 clkConstrained = ~clkConstrained;

    always @(posedge clkConstrained) begin
        cycle_count <= cycle_count + 1;
    end

    soc_mem_top #(
        .FMAX_MHZ (4),
        .RAM_WORDS(RAM_WORDS)
    ) UUT (
        .clkConstrained(clkConstrained),
        .arst_n        (arst_n),
        .ireq          (ireq),
        .iresp         (iresp),
        .dreq          (dreq),
        .dresp         (dresp),
        .timer_irq     (timer_irq)
    );

    bind mem_map_ctrl soc_mem_properties u_props (
        .clkConstrained(clkConstrained),
        .arst_n        (arst_n),
        .wb_in         (wb_in),
        .wb_out        (wb_out)
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // any byte address whose word access stays inside the RAM
    function automatic logic [31:0] rand_ram_addr();
        logic [31:0] a;
        a = rand_bits(BW);
        if (a > 32'(RAM_BYTES - 4)) begin
            a = a - 32'd4;
        end
        return a;
    endfunction

    function automatic logic [7:0] byte_at(input logic [31:0] a);
        return (a < 32'(RAM_BYTES)) ? shadow[a[BW-1:0]] : 8'h00;
    endfunction

    // expected load result, little endian, extended per op
    function automatic logic [31:0] ref_load(input mem_pkg::mem_op_e op, input logic [31:0] a);
        logic [31:0] w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = byte_at(a + 32'(k));
        end
        case (op)
            mem_pkg::LB:  return {{24{w[7]}}, w[7:0]};
            mem_pkg::LH:  return {{16{w[15]}}, w[15:0]};
            mem_pkg::LBU: return {24'h0, w[7:0]};
            mem_pkg::LHU: return {16'h0, w[15:0]};
            default:      return w;
        endcase
    endfunction

    function automatic void store_shadow(input mem_pkg::mem_op_e op, input logic [31:0] a,
                                         input logic [31:0] d);
        logic [31:0] b;
        int          n;
        n = (op == mem_pkg::SB) ? 1 : (op == mem_pkg::SH) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            b = a + 32'(k);
            if (b < 32'(RAM_BYTES)) begin
                shadow[b[BW-1:0]] = d[8*k +: 8];
            end
        end
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic end_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    // one request on the fetch or data port, held until its response pulse
    task automatic issue_and_wait(input bit fetch, input mem_pkg::mem_op_e op,
                                  input logic [31:0] a, input logic [31:0] wd, input bit chk,
                                  output logic [31:0] rd, output int lat);
        bit seen = 1'b0;
        lat = 0;
        @(posedge clkConstrained);
        #1;
        if (fetch) begin
            ireq.valid = 1'b1;
            ireq.addr  = a;
            exp_i.push_back({chk, ref_load(mem_pkg::LW, a)});
        end else begin
            dreq.valid = 1'b1;
            dreq.op    = op;
            dreq.addr  = a;
            dreq.wdata = wd;
            exp_d.push_back({chk, ref_load(op, a)});
        end
        while (!seen) begin
            @(negedge clkConstrained);
            seen = fetch ? iresp.valid : dresp.valid;
            rd   = fetch ? iresp.rdata : dresp.rdata;
            if (!seen) begin
                lat++;
                if (lat >= TIMEOUT) begin
                    errors++;
                    $display("Timeout: no %s response within %0d cycles",
                             fetch ? "fetch" : "data", TIMEOUT);
                    end_run();
                end
            end
        end
        @(posedge clkConstrained);
        #1;
        if (fetch) begin
            ireq.valid = 1'b0;
        end else begin
            dreq.valid = 1'b0;
        end
    endtask

    task automatic wait_irq(input logic level);
        int n = 0;
        while (timer_irq !== level) begin
            @(negedge clkConstrained);
            n++;
            if (n >= TIMEOUT) begin
                errors++;
                $display("Timeout: timer_irq did not reach %b within %0d cycles", level, TIMEOUT);
                end_run();
            end
        end
    endtask

    // response checker, every pulse must match one pending request
    always @(negedge clkConstrained) begin
        logic [32:0] e;
        if (arst_n && dresp.valid) begin
            d_count++;
            if (exp_d.size() == 0) begin
                errors++;
                $display("Unexpected data response at %0t with no request pending", $time);
            end else begin
                e = exp_d.pop_front();
                d_stamp = cycle_count;
                if (e[32]) begin
                    check_equal(dresp.rdata, e[31:0], "data load");
                end
            end
        end
        if (arst_n && iresp.valid) begin
            i_count++;
            if (exp_i.size() == 0) begin
                errors++;
                $display("Unexpected fetch response at %0t with no request pending", $time);
            end else begin
                e = exp_i.pop_front();
                i_stamp = cycle_count;
                check_equal(iresp.rdata, e[31:0], "fetch");
            end
        end
    end

    initial begin
        logic [31:0]      a;
        logic [31:0]      rd;
        logic [31:0]      t1;
        logic [31:0]      t2;
        int               lat;
        int               d_before;
        int               i_before;
        mem_pkg::mem_op_e op;
        lfsr   = 32'h0e6ef083;
        arst_n = 1'b0;
        ireq   = '0;
        dreq   = '0;
        repeat (10) @(posedge clkConstrained);
        #1;
        arst_n = 1'b1;
        @(negedge clkConstrained);
        check_equal({29'h0, iresp.valid, dresp.valid, timer_irq}, 32'h0, "outputs after reset");

        // known contents in every RAM word
        for (int w = 0; w < RAM_WORDS; w++) begin
            a  = 32'(w) << 2;
            t1 = (a * 32'h9E37_79B1) ^ 32'h3C2D_1E0F;
            issue_and_wait(1'b0, mem_pkg::SW, a, t1, 1'b0, rd, lat);
            store_shadow(mem_pkg::SW, a, t1);
        end

        // aligned words on a free bus
        repeat (40) begin
            a  = rand_bits(BW - 2) << 2;
            t1 = rand_bits(32);
            issue_and_wait(1'b0, mem_pkg::SW, a, t1, 1'b0, rd, lat);
            store_shadow(mem_pkg::SW, a, t1);
            check_equal(32'(lat), 32'd3, "aligned store latency");
            issue_and_wait(1'b0, mem_pkg::LW, rand_bits(BW - 2) << 2, 32'h0, 1'b1, rd, lat);
            check_equal(32'(lat), 32'd3, "aligned load latency");
            issue_and_wait(1'b1, mem_pkg::LW, rand_bits(BW - 2) << 2, 32'h0, 1'b1, rd, lat);
            check_equal(32'(lat), 32'd3, "fetch latency");
        end

        // sized accesses at any alignment, often split over two words
        repeat (200) begin
            a = rand_ram_addr();
            if (rand_bits(1) == 32'd1) begin
                op = mem_pkg::mem_op_e'(3'(32'd5 + rand_bits(2) % 32'd3));
                t1 = rand_bits(32);
                issue_and_wait(1'b0, op, a, t1, 1'b0, rd, lat);
                store_shadow(op, a, t1);
            end else begin
                op = mem_pkg::mem_op_e'(3'(rand_bits(3) % 32'd5));
                issue_and_wait(1'b0, op, a, 32'h0, 1'b1, rd, lat);
            end
        end

        // both ports at once, then a quiet window for repeated pulses
        repeat (10) begin
            a  = rand_ram_addr();
            t2 = rand_bits(BW - 2) << 2;
            op = mem_pkg::mem_op_e'(3'(rand_bits(3) % 32'd5));
            d_before = d_count;
            i_before = i_count;
            fork
                issue_and_wait(1'b0, op, a, 32'h0, 1'b1, rd, lat);
                issue_and_wait(1'b1, mem_pkg::LW, t2, 32'h0, 1'b1, t1, lat);
            join
            repeat (8) @(posedge clkConstrained);
            check_equal({31'h0, d_stamp <= i_stamp}, 32'd1, "data response before fetch");
            check_equal(32'(d_count - d_before), 32'd1, "data responses per request");
            check_equal(32'(i_count - i_before), 32'd1, "fetch responses per request");
        end

        // unmapped space, the word past the RAM must not alias word 0
        issue_and_wait(1'b0, mem_pkg::LW, 32'h4000_0000 | (rand_bits(12) << 2), 32'h0, 1'b1,
                       rd, lat);
        issue_and_wait(1'b0, mem_pkg::SW, 32'(RAM_BYTES), rand_bits(32), 1'b0, rd, lat);
        issue_and_wait(1'b0, mem_pkg::LW, 32'h0, 32'h0, 1'b1, rd, lat);
        issue_and_wait(1'b1, mem_pkg::LW, 32'(RAM_BYTES), 32'h0, 1'b1, rd, lat);

        // timer
        issue_and_wait(1'b0, mem_pkg::LW, mem_pkg::TIMER_BASE, 32'h0, 1'b0, t1, lat);
        repeat (20) @(posedge clkConstrained);
        issue_and_wait(1'b0, mem_pkg::LW, mem_pkg::TIMER_BASE, 32'h0, 1'b0, t2, lat);
        check_equal({31'h0, t2 >= t1}, 32'd1, "mtime not decreasing");
        issue_and_wait(1'b0, mem_pkg::SW, mem_pkg::TIMER_BASE + 32'd8, t2 + 32'd3, 1'b0, rd, lat);
        issue_and_wait(1'b0, mem_pkg::SW, mem_pkg::TIMER_BASE + 32'd12, 32'h0, 1'b0, rd, lat);
        wait_irq(1'b1);
        issue_and_wait(1'b0, mem_pkg::LW, mem_pkg::TIMER_BASE, 32'h0, 1'b0, t1, lat);
        check_equal({31'h0, t1 >= t2 + 32'd3}, 32'd1, "mtime reached mtimecmp");
        issue_and_wait(1'b0, mem_pkg::SW, mem_pkg::TIMER_BASE + 32'd12, 32'hFFFF_FFFF, 1'b0,
                       rd, lat);
        issue_and_wait(1'b0, mem_pkg::SW, mem_pkg::TIMER_BASE + 32'd8, 32'hFFFF_FFFF, 1'b0,
                       rd, lat);
        wait_irq(1'b0);
        end_run();
    end

endmodule

// File: project.f
common/mem_pkg.sv
mem_map/word_ram.sv
mem_map/machine_timer.sv
mem_map/mem_map_ctrl.sv
verilog/data_access_splitter.sv
verilog/mem_cmd_arbiter.sv
verilog/soc_mem_top.sv
sim/soc_mem_properties.sv
sim/tb_soc_mem.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_mem \
    -f project.f -o tb_soc_mem
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_soc_mem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with errors$" "$LOG"; then
    exit 1
fi
exit 0
